// File: sources.f
+incdir+hdl
hdl/riscv_pkg.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/core_control.sv
hdl/riscv_core.sv
dv/tb_riscv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the riscv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_riscv_core -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build returned status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation run returned status $status"
  exit "$status"
fi

exit 0

// File: dv/tb_riscv_core.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module tb_riscv_core;

  // instruction kinds the generator can produce
  // the trapping kinds come last
  typedef enum int {
    GEN_LUI, GEN_AUIPC, GEN_JAL, GEN_JALR, GEN_BRANCH,
    GEN_LOAD, GEN_STORE, GEN_OP_IMM, GEN_OP_REG,
    GEN_BAD_ENCODING, GEN_BAD_LOAD, GEN_BAD_STORE,
    GEN_BAD_JAL, GEN_BAD_JALR, GEN_BAD_BRANCH
  } gen_kind_t;

  logic clk;
  logic reset;
  logic mem_ready;
  riscv_pkg::word_t mem_rdata;
  logic mem_valid;
  logic mem_instr;
  riscv_pkg::word_t mem_addr;
  riscv_pkg::word_t mem_wdata;
  riscv_pkg::wstrb_t mem_wstrb;
  logic trap;

  logic [31:0] seed;
  riscv_pkg::word_t model_regs [`REG_COUNT];
  riscv_pkg::word_t model_pc;
  int retired;
  bit did_trap;

  riscv_core riscv_core_inst (
    .clk       (clk),
    .reset     (reset),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .trap      (trap)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    // low LCG bits are weak
    return int'(r[31:8]) % n;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input riscv_pkg::word_t expected,
                            input riscv_pkg::word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_strb(input string name, input riscv_pkg::wstrb_t expected,
                            input riscv_pkg::wstrb_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // ISA rules for OP and OP-IMM
  // alt selects SUB or SRA
  function automatic riscv_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                               input riscv_pkg::word_t x,
                                               input riscv_pkg::word_t y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return {31'd0, $signed(x) < $signed(y)};
      3'd3: return {31'd0, x < y};
      3'd4: return x ^ y;
      3'd5: return alt ? riscv_pkg::word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic bit ref_branch(input logic [2:0] f3, input riscv_pkg::word_t x,
                                    input riscv_pkg::word_t y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    mem_ready = 1'b0;
    repeat (10) begin
      @(posedge clk);
      #1;
    end
    reset = 1'b0;
    model_pc = `RESET_PC;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    check_bit("mem_valid after reset", 1'b0, mem_valid);
    check_bit("mem_instr after reset", 1'b0, mem_instr);
    check_strb("mem_wstrb after reset", 4'h0, mem_wstrb);
    check_bit("trap after reset", 1'b0, trap);
  endtask

  task automatic wait_request(input string what);
    int cycles;
    cycles = 0;
    while (mem_valid !== 1'b1) begin
      if (cycles == 20) begin
        abort_run($sformatf("no memory request for the %s within 20 cycles", what));
      end else begin
        @(posedge clk);
        #1;
        cycles++;
      end
    end
  endtask

  // stall 0 to 3 cycles, watching the request hold, then complete it
  task automatic respond(input riscv_pkg::word_t data);
    riscv_pkg::word_t addr_seen;
    riscv_pkg::word_t wdata_seen;
    riscv_pkg::wstrb_t strb_seen;
    logic instr_seen;
    int delay;
    addr_seen = mem_addr;
    wdata_seen = mem_wdata;
    strb_seen = mem_wstrb;
    instr_seen = mem_instr;
    delay = rand_below(4);
    for (int i = 0; i < delay; i++) begin
      @(posedge clk);
      #1;
      check_bit("mem_valid during stall", 1'b1, mem_valid);
      check_word("mem_addr during stall", addr_seen, mem_addr);
      check_word("mem_wdata during stall", wdata_seen, mem_wdata);
      check_strb("mem_wstrb during stall", strb_seen, mem_wstrb);
      check_bit("mem_instr during stall", instr_seen, mem_instr);
    end
    mem_ready = 1'b1;
    mem_rdata = data;
    @(posedge clk);
    #1;
    mem_ready = 1'b0;
    mem_rdata = lcg_next();
  endtask

  task automatic expect_trap(input string what);
    int cycles;
    cycles = 0;
    while (trap !== 1'b1) begin
      if (mem_valid === 1'b1) begin
        abort_run($sformatf("memory request issued instead of a trap on %s", what));
      end else if (cycles == 20) begin
        abort_run($sformatf("trap did not rise on %s within 20 cycles", what));
      end else begin
        @(posedge clk);
        #1;
        cycles++;
      end
    end
    repeat (50) begin
      @(posedge clk);
      #1;
      check_bit("trap held", 1'b1, trap);
      check_bit("mem_valid after trap", 1'b0, mem_valid);
    end
  endtask

  // one fetch, generate, model and check cycle
  task automatic execute_one(input bit forced, input gen_kind_t forced_kind,
                             output bit trapped);
    gen_kind_t kind;
    riscv_pkg::word_t insn;
    riscv_pkg::word_t a;
    riscv_pkg::word_t b;
    riscv_pkg::word_t res;
    riscv_pkg::word_t addr;
    riscv_pkg::word_t next_pc;
    riscv_pkg::word_t data;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [20:0] off21;
    logic [12:0] off13;
    logic [6:0] f7;
    logic [2:0] f3;
    bit writes;
    bit bad;

    wait_request("instruction fetch");
    check_bit("fetch mem_instr", 1'b1, mem_instr);
    check_strb("fetch mem_wstrb", 4'h0, mem_wstrb);
    check_word("fetch address", model_pc, mem_addr);

    if (forced) begin
      kind = forced_kind;
    end else if (rand_below(64) == 0) begin
      kind = gen_kind_t'(int'(GEN_BAD_ENCODING) + rand_below(6));
    end else begin
      kind = gen_kind_t'(rand_below(9));
    end
    bad = (kind >= GEN_BAD_ENCODING);
    rd = riscv_pkg::reg_addr_t'(rand_below(`REG_COUNT));
    rs1 = riscv_pkg::reg_addr_t'(rand_below(`REG_COUNT));
    rs2 = riscv_pkg::reg_addr_t'(rand_below(`REG_COUNT));
    a = model_regs[rs1];
    b = model_regs[rs2];
    imm12 = 12'(lcg_next());
    imm20 = 20'(lcg_next());
    off21 = 21'(lcg_next());
    off21[1:0] = 2'b00;
    off13 = 13'(lcg_next());
    off13[1:0] = 2'b00;
    f3 = 3'(rand_below(8));
    f7 = 7'd0;
    next_pc = model_pc + `INSTR_BYTES;
    res = '0;
    addr = '0;
    writes = 1'b0;

    case (kind)
      GEN_LUI, GEN_AUIPC: begin
        insn = {imm20, rd, (kind == GEN_LUI) ? `OP_LUI : `OP_AUIPC};
        res = (kind == GEN_LUI) ? {imm20, 12'd0} : model_pc + {imm20, 12'd0};
        writes = 1'b1;
      end
      GEN_JAL, GEN_BAD_JAL: begin
        off21[1] = bad;
        insn = {off21[20], off21[10:1], off21[11], off21[19:12], rd, `OP_JAL};
        next_pc = model_pc + {{11{off21[20]}}, off21};
        res = model_pc + `INSTR_BYTES;
        writes = 1'b1;
      end
      GEN_JALR, GEN_BAD_JALR: begin
        imm12[1:0] = (bad ? 2'b10 : 2'b00) - a[1:0];
        insn = {imm12, rs1, 3'b000, rd, `OP_JALR};
        addr = a + {{20{imm12[11]}}, imm12};
        next_pc = {addr[31:1], 1'b0};
        res = model_pc + `INSTR_BYTES;
        writes = 1'b1;
      end
      GEN_BRANCH, GEN_BAD_BRANCH: begin
        if (bad) begin
          // BEQ on one register is always taken
          f3 = 3'd0;
          rs2 = rs1;
          b = a;
          off13[1] = 1'b1;
        end else if (f3 >= 3'd2) begin
          f3 = f3 - 3'd2;
          if (f3 >= 3'd2) begin
            f3 = f3 + 3'd2;
          end
        end
        insn = {off13[12], off13[10:5], rs2, rs1, f3, off13[4:1], off13[11], `OP_BRANCH};
        if (ref_branch(f3, a, b)) begin
          next_pc = model_pc + {{19{off13[12]}}, off13};
        end
      end
      GEN_LOAD, GEN_BAD_LOAD, GEN_STORE, GEN_BAD_STORE: begin
        imm12[1:0] = (bad ? 2'(1 + rand_below(3)) : 2'b00) - a[1:0];
        addr = a + {{20{imm12[11]}}, imm12};
        if (kind == GEN_LOAD || kind == GEN_BAD_LOAD) begin
          insn = {imm12, rs1, 3'b010, rd, `OP_LOAD};
        end else begin
          insn = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], `OP_STORE};
        end
      end
      GEN_OP_IMM: begin
        if (f3 == 3'd1) begin
          imm12[11:5] = 7'd0;
        end else if (f3 == 3'd5) begin
          imm12[11:5] = {1'b0, imm12[10], 5'd0};
        end
        insn = {imm12, rs1, f3, rd, `OP_IMM};
        res = ref_alu(f3, f3 == 3'd5 && imm12[10], a, {{20{imm12[11]}}, imm12});
        writes = 1'b1;
      end
      GEN_OP_REG: begin
        if ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) begin
          f7 = 7'b0100000;
        end
        insn = {f7, rs2, rs1, f3, rd, `OP_REG};
        res = ref_alu(f3, f7[5], a, b);
        writes = 1'b1;
      end
      default: begin
        // ECALL, LB, SB and a multiply are all outside the kept set
        case (rand_below(4))
          0: insn = 32'h0000_0073;
          1: insn = {imm12, rs1, 3'b000, rd, `OP_LOAD};
          2: insn = {imm12[11:5], rs2, rs1, 3'b000, imm12[4:0], `OP_STORE};
          default: insn = {7'b0000001, rs2, rs1, f3, rd, `OP_REG};
        endcase
      end
    endcase
    trapped = bad;

    respond(insn);
    if (bad) begin
      expect_trap(kind.name());
    end else begin
      if (kind == GEN_LOAD) begin
        wait_request("load");
        check_bit("load mem_instr", 1'b0, mem_instr);
        check_strb("load mem_wstrb", 4'h0, mem_wstrb);
        check_word("load address", addr, mem_addr);
        data = lcg_next();
        respond(data);
        res = data;
        writes = 1'b1;
      end else if (kind == GEN_STORE) begin
        wait_request("store");
        check_bit("store mem_instr", 1'b0, mem_instr);
        check_strb("store mem_wstrb", 4'hf, mem_wstrb);
        check_word("store address", addr, mem_addr);
        check_word("store data", b, mem_wdata);
        respond(lcg_next());
      end
      if (writes && rd != 5'd0) begin
        model_regs[rd] = res;
      end
      model_pc = next_pc;
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    seed = 32'hbd2a_543d;
    retired = 0;
    apply_reset();
    while (retired < 2000) begin
      execute_one(1'b0, GEN_LUI, did_trap);
      if (did_trap) begin
        apply_reset();
      end else begin
        retired++;
      end
    end
    // every trap cause once more from a clean reset
    for (int k = int'(GEN_BAD_ENCODING); k <= int'(GEN_BAD_BRANCH); k++) begin
      execute_one(1'b1, gen_kind_t'(k), did_trap);
      apply_reset();
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: hdl/riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_ready,
  input  riscv_pkg::word_t  mem_rdata,
  output logic              mem_valid,
  output logic              mem_instr,
  output riscv_pkg::word_t  mem_addr,
  output riscv_pkg::word_t  mem_wdata,
  output riscv_pkg::wstrb_t mem_wstrb,
  output logic              trap
);

  riscv_pkg::word_t        instr;
  riscv_pkg::instr_class_t instr_class;
  riscv_pkg::alu_op_t      alu_op;
  logic                    use_imm;
  riscv_pkg::reg_addr_t    rs1;
  riscv_pkg::reg_addr_t    rs2;
  riscv_pkg::reg_addr_t    rd;
  riscv_pkg::word_t        imm;
  logic                    is_valid;
  riscv_pkg::word_t        rs1_data;
  riscv_pkg::word_t        rs2_data;
  riscv_pkg::word_t        operand_b;
  riscv_pkg::word_t        result;
  logic                    branch_taken;
  logic                    rf_we;
  riscv_pkg::word_t        wdata;

  core_control core_control_inst (
    .clk          (clk),
    .reset        (reset),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata),
    .instr_class  (instr_class),
    .alu_op       (alu_op),
    .use_imm      (use_imm),
    .imm          (imm),
    .is_valid     (is_valid),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (result),
    .branch_taken (branch_taken),
    .mem_valid    (mem_valid),
    .mem_instr    (mem_instr),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_wstrb    (mem_wstrb),
    .trap         (trap),
    .instr        (instr),
    .operand_b    (operand_b),
    .rf_we        (rf_we),
    .wdata        (wdata)
  );

  instr_decoder instr_decoder_inst (
    .instr       (instr),
    .instr_class (instr_class),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .is_valid    (is_valid)
  );

  alu alu_inst (
    .alu_op       (alu_op),
    .operand_a    (rs1_data),
    .operand_b    (operand_b),
    .result       (result),
    .branch_taken (branch_taken)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rf_we    (rf_we),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

// File: hdl/core_control.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module core_control (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    mem_ready,
  input  riscv_pkg::word_t        mem_rdata,
  input  riscv_pkg::instr_class_t instr_class,
  input  riscv_pkg::alu_op_t      alu_op,
  input  logic                    use_imm,
  input  riscv_pkg::word_t        imm,
  input  logic                    is_valid,
  input  riscv_pkg::word_t        rs1_data,
  input  riscv_pkg::word_t        rs2_data,
  input  riscv_pkg::word_t        result,
  input  logic                    branch_taken,
  output logic                    mem_valid,
  output logic                    mem_instr,
  output riscv_pkg::word_t        mem_addr,
  output riscv_pkg::word_t        mem_wdata,
  output riscv_pkg::wstrb_t       mem_wstrb,
  output logic                    trap,
  output riscv_pkg::word_t        instr,
  output riscv_pkg::word_t        operand_b,
  output logic                    rf_we,
  output riscv_pkg::word_t        wdata
);

  riscv_pkg::cpu_state_t state;
  riscv_pkg::word_t pc;
  riscv_pkg::word_t next_pc;
  riscv_pkg::word_t pc_plus4;
  riscv_pkg::word_t data_addr;
  riscv_pkg::word_t jump_target;
  logic compare_op;

  assign operand_b = use_imm ? imm : rs2_data;
  assign rf_we     = (state == riscv_pkg::WRITE_BACK);
  assign pc_plus4  = pc + `INSTR_BYTES;
  // rs1 + imm serves both LW/SW and JALR
  assign data_addr = rs1_data + imm;
  // instr[3] is set for JAL and clear for JALR
  assign jump_target = instr[3] ? pc + imm : {data_addr[`XLEN-1:1], 1'b0};
  assign compare_op  = alu_op inside {riscv_pkg::ALU_EQ, riscv_pkg::ALU_NE,
                                      riscv_pkg::ALU_LT, riscv_pkg::ALU_GE,
                                      riscv_pkg::ALU_LTU, riscv_pkg::ALU_GEU};

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= riscv_pkg::FETCH;
      next_pc   <= `RESET_PC;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      trap      <= 1'b0;
    end else begin
      case (state)
        riscv_pkg::FETCH: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= '0;
          mem_addr  <= next_pc;
          state     <= riscv_pkg::WAIT_FETCH;
        end
        riscv_pkg::WAIT_FETCH: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            pc        <= mem_addr;
            instr     <= mem_rdata;
            state     <= riscv_pkg::EXECUTE;
          end
        end
        riscv_pkg::EXECUTE: begin
          next_pc <= pc_plus4;
          if (!is_valid) begin
            state <= riscv_pkg::TRAP;
          end else begin
            case (instr_class)
              riscv_pkg::CLASS_LUI: begin
                wdata <= imm;
                state <= riscv_pkg::WRITE_BACK;
              end
              riscv_pkg::CLASS_AUIPC: begin
                wdata <= pc + imm;
                state <= riscv_pkg::WRITE_BACK;
              end
              riscv_pkg::CLASS_JUMP: begin
                wdata   <= pc_plus4;
                next_pc <= jump_target;
                state   <= riscv_pkg::WRITE_BACK;
              end
              riscv_pkg::CLASS_BRANCH: begin
                if (branch_taken) begin
                  next_pc <= pc + imm;
                end
                state <= riscv_pkg::CHECK_PC;
              end
              riscv_pkg::CLASS_LOAD, riscv_pkg::CLASS_STORE: begin
                if (|data_addr[1:0]) begin
                  state <= riscv_pkg::TRAP;
                end else if (instr_class == riscv_pkg::CLASS_STORE) begin
                  mem_valid <= 1'b1;
                  mem_instr <= 1'b0;
                  mem_addr  <= data_addr;
                  mem_wdata <= rs2_data;
                  mem_wstrb <= '1;
                  state     <= riscv_pkg::WAIT_STORE;
                end else begin
                  mem_valid <= 1'b1;
                  mem_instr <= 1'b0;
                  mem_addr  <= data_addr;
                  state     <= riscv_pkg::WAIT_LOAD;
                end
              end
              default: begin
                wdata <= result;
                state <= riscv_pkg::WRITE_BACK;
              end
            endcase
          end
        end
        riscv_pkg::WAIT_LOAD: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            wdata     <= mem_rdata;
            state     <= riscv_pkg::WRITE_BACK;
          end
        end
        riscv_pkg::WAIT_STORE: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state     <= riscv_pkg::FETCH;
          end
        end
        riscv_pkg::WRITE_BACK: begin
          // jumps still have to prove their target aligned
          state <= (instr_class == riscv_pkg::CLASS_JUMP) ? riscv_pkg::CHECK_PC
                                                          : riscv_pkg::FETCH;
        end
        riscv_pkg::CHECK_PC: begin
          state <= |next_pc[1:0] ? riscv_pkg::TRAP : riscv_pkg::FETCH;
        end
        default: begin
          trap <= 1'b1;
        end
      endcase
    end
  end

  // request fields hold while the memory stalls
  assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata) &&
                                $stable(mem_wstrb) && $stable(mem_instr))
    else $error("core_control: memory request changed before mem_ready");

  assert property (@(posedge clk) disable iff (reset) trap |=> trap)
    else $error("core_control: trap cleared without reset");

  // the decoder pairs every branch with one of the compare operations
  assert property (@(posedge clk) disable iff (reset)
    state == riscv_pkg::EXECUTE && instr_class == riscv_pkg::CLASS_BRANCH |-> compare_op)
    else $error("core_control: branch decoded without a compare operation");

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module reg_file (
  input  logic                 clk,
  input  logic                 reset,
  input  riscv_pkg::reg_addr_t rs1,
  input  riscv_pkg::reg_addr_t rs2,
  input  riscv_pkg::reg_addr_t rd,
  input  logic                 rf_we,
  input  riscv_pkg::word_t     wdata,
  output riscv_pkg::word_t     rs1_data,
  output riscv_pkg::word_t     rs2_data
);

  riscv_pkg::word_t regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 survives every write-back the controller issues
  assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
    else $error("reg_file: x0 holds a nonzero value");

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module alu (
  input  riscv_pkg::alu_op_t alu_op,
  input  riscv_pkg::word_t   operand_a,
  input  riscv_pkg::word_t   operand_b,
  output riscv_pkg::word_t   result,
  output logic               branch_taken
);

  logic [$clog2(`XLEN)-1:0] shamt;
  logic equal;
  logic signed_lt;
  logic unsigned_lt;

  assign shamt       = operand_b[$clog2(`XLEN)-1:0];
  assign equal       = (operand_a == operand_b);
  assign signed_lt   = $signed(operand_a) < $signed(operand_b);
  assign unsigned_lt = operand_a < operand_b;

  always_comb begin
    case (alu_op)
      riscv_pkg::ALU_ADD:  result = operand_a + operand_b;
      riscv_pkg::ALU_SUB:  result = operand_a - operand_b;
      riscv_pkg::ALU_SLL:  result = operand_a << shamt;
      riscv_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, signed_lt};
      riscv_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, unsigned_lt};
      riscv_pkg::ALU_XOR:  result = operand_a ^ operand_b;
      riscv_pkg::ALU_SRL:  result = operand_a >> shamt;
      riscv_pkg::ALU_SRA:  result = riscv_pkg::word_t'($signed(operand_a) >>> shamt);
      riscv_pkg::ALU_OR:   result = operand_a | operand_b;
      riscv_pkg::ALU_AND:  result = operand_a & operand_b;
      default:             result = '0;
    endcase
  end

  always_comb begin
    case (alu_op)
      riscv_pkg::ALU_EQ:  branch_taken = equal;
      riscv_pkg::ALU_NE:  branch_taken = !equal;
      riscv_pkg::ALU_LT:  branch_taken = signed_lt;
      riscv_pkg::ALU_GE:  branch_taken = !signed_lt;
      riscv_pkg::ALU_LTU: branch_taken = unsigned_lt;
      riscv_pkg::ALU_GEU: branch_taken = !unsigned_lt;
      default:            branch_taken = 1'b0;
    endcase
  end

  // checked once the decoder has settled in each time step
  always_comb begin
    assert final (!$isunknown(alu_op) &&
                  alu_op inside {[riscv_pkg::ALU_ADD:riscv_pkg::ALU_GEU]})
      else $error("alu: operation outside alu_op_t");
  end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps
`include "riscv_defines.svh"

module instr_decoder (
  input  riscv_pkg::word_t        instr,
  output riscv_pkg::instr_class_t instr_class,
  output riscv_pkg::alu_op_t      alu_op,
  output logic                    use_imm,
  output riscv_pkg::reg_addr_t    rs1,
  output riscv_pkg::reg_addr_t    rs2,
  output riscv_pkg::reg_addr_t    rd,
  output riscv_pkg::word_t        imm,
  output logic                    is_valid
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  riscv_pkg::word_t i_imm;
  riscv_pkg::word_t s_imm;
  riscv_pkg::word_t b_imm;
  riscv_pkg::word_t u_imm;
  riscv_pkg::word_t j_imm;
  riscv_pkg::alu_op_t arith_op;
  riscv_pkg::alu_op_t cmp_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  // branches and stores carry immediate bits in the rd field
  assign rd = (opcode == `OP_BRANCH || opcode == `OP_STORE) ? '0 : instr[11:7];

  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 map shared by OP and OP-IMM, funct7[5] picks SUB and SRA
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == `OP_REG && funct7[5]) ? riscv_pkg::ALU_SUB
                                                          : riscv_pkg::ALU_ADD;
      3'b001:  arith_op = riscv_pkg::ALU_SLL;
      3'b010:  arith_op = riscv_pkg::ALU_SLT;
      3'b011:  arith_op = riscv_pkg::ALU_SLTU;
      3'b100:  arith_op = riscv_pkg::ALU_XOR;
      3'b101:  arith_op = funct7[5] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      3'b110:  arith_op = riscv_pkg::ALU_OR;
      default: arith_op = riscv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  cmp_op = riscv_pkg::ALU_EQ;
      3'b001:  cmp_op = riscv_pkg::ALU_NE;
      3'b100:  cmp_op = riscv_pkg::ALU_LT;
      3'b101:  cmp_op = riscv_pkg::ALU_GE;
      3'b110:  cmp_op = riscv_pkg::ALU_LTU;
      default: cmp_op = riscv_pkg::ALU_GEU;
    endcase
  end

  always_comb begin
    instr_class = riscv_pkg::CLASS_ALU;
    alu_op      = riscv_pkg::ALU_ADD;
    use_imm     = 1'b0;
    imm         = '0;
    is_valid    = 1'b0;
    case (opcode)
      `OP_LUI: begin
        instr_class = riscv_pkg::CLASS_LUI;
        imm         = u_imm;
        is_valid    = 1'b1;
      end
      `OP_AUIPC: begin
        instr_class = riscv_pkg::CLASS_AUIPC;
        imm         = u_imm;
        is_valid    = 1'b1;
      end
      `OP_JAL: begin
        instr_class = riscv_pkg::CLASS_JUMP;
        imm         = j_imm;
        is_valid    = 1'b1;
      end
      `OP_JALR: begin
        instr_class = riscv_pkg::CLASS_JUMP;
        use_imm     = 1'b1;
        imm         = i_imm;
        is_valid    = (funct3 == 3'b000);
      end
      `OP_BRANCH: begin
        instr_class = riscv_pkg::CLASS_BRANCH;
        alu_op      = cmp_op;
        imm         = b_imm;
        is_valid    = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      // only word accesses are kept
      `OP_LOAD: begin
        instr_class = riscv_pkg::CLASS_LOAD;
        use_imm     = 1'b1;
        imm         = i_imm;
        is_valid    = (funct3 == 3'b010);
      end
      `OP_STORE: begin
        instr_class = riscv_pkg::CLASS_STORE;
        use_imm     = 1'b1;
        imm         = s_imm;
        is_valid    = (funct3 == 3'b010);
      end
      `OP_IMM: begin
        alu_op   = arith_op;
        use_imm  = 1'b1;
        imm      = i_imm;
        is_valid = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                   (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                   1'b1;
      end
      `OP_REG: begin
        alu_op   = arith_op;
        is_valid = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      default: begin
        is_valid = 1'b0;
      end
    endcase
  end

endmodule

// File: hdl/riscv_pkg.sv
`include "riscv_defines.svh"

package riscv_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;
  typedef logic [`XLEN/8-1:0] wstrb_t;

  // the last six are the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_t;

  typedef enum logic [2:0] {
    CLASS_LUI, CLASS_AUIPC, CLASS_JUMP, CLASS_BRANCH,
    CLASS_LOAD, CLASS_STORE, CLASS_ALU
  } instr_class_t;

  typedef enum logic [2:0] {
    FETCH, WAIT_FETCH, EXECUTE, WAIT_LOAD,
    WAIT_STORE, WRITE_BACK, CHECK_PC, TRAP
  } cpu_state_t;

endpackage

// File: hdl/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// architectural sizes
`define XLEN 32
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000
`define INSTR_BYTES 32'd4

// major opcodes, instr[6:0]
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

`endif
